/* rtl/flash_pkg.sv */
package flash_pkg;

	// W25Q16 instruction set, only what the writer sends
	typedef enum logic [7:0] {
		OP_WRITE_ENABLE = 8'h06,
		OP_PAGE_PROGRAM = 8'h02,
		OP_READ_STATUS1 = 8'h05
	} flash_op_t;

	typedef enum logic [3:0] {
		IDLE,
		WREN,      // write enable, own frame
		WREN_GAP,
		PROG_CMD,
		PROG_ADDR,
		PROG_DATA,
		POLL_CMD,
		POLL_READ, // dummy byte, status comes back
		FINISH
	} seq_state_t;

	// one byte for the shifter
	typedef struct packed {
		logic [7:0] data;
		logic       end_frame; // release cs_n after this byte
	} spi_byte_t;

	// table layout
	localparam logic [7:0] CFG_ADDR_INDEX = 8'd2;
	localparam logic [7:0] CFG_FIRST_DATA = 8'd3;
	localparam logic [7:0] CFG_LAST_INDEX = 8'd150;

	// status register 1
	localparam int STATUS_BUSY_BIT = 0;

endpackage

/* rtl/w25q16_cfg_data.sv */
`timescale 1ns/1ps

module w25q16_cfg_data import flash_pkg::*; (
	input  logic [7:0]  index,
	output logic [23:0] spi_wrdata
);

	localparam logic [7:0] ADDR_BLOCK  = 8'h00;
	localparam logic [7:0] ADDR_SECTOR = 8'h04;
	localparam logic [7:0] ADDR_PAGE   = 8'h25;

	logic [7:0] entry_num; // (index + 1) mod 100
	logic [3:0] tens;
	logic [3:0] ones;
	logic       is_data;

	// data bytes count up in BCD, wrapping 99 -> 00
	always_comb begin
		entry_num = (index + 8'd1) % 8'd100;
		tens      = 4'(entry_num / 8'd10);
		ones      = 4'(entry_num % 8'd10);
	end

	assign is_data = (index >= CFG_FIRST_DATA) && (index <= CFG_LAST_INDEX);

	always_comb begin
		case (index)
			8'd0: begin
				spi_wrdata = {16'd0, OP_WRITE_ENABLE};
			end
			8'd1: begin
				spi_wrdata = {16'd0, OP_PAGE_PROGRAM};
			end
			CFG_ADDR_INDEX: begin
				spi_wrdata = {ADDR_BLOCK, ADDR_SECTOR, ADDR_PAGE}; // sent top byte first
			end
			default: begin
				if (is_data) begin
					spi_wrdata = {16'd0, tens, ones};
				end else begin
					spi_wrdata = 24'd0; // past the end of the table
				end
			end
		endcase
	end

endmodule

/* rtl/spi_byte_engine.sv */
`timescale 1ns/1ps

module spi_byte_engine import flash_pkg::*; #(
	parameter int CLK_DIV = 2
) (
	input  logic       clk,
	input  logic       arst_n,
	input  spi_byte_t  tx,
	input  logic       tx_valid,
	output logic       tx_ready,
	output logic [7:0] rx_data,
	output logic       rx_valid,
	output logic       cs_n,
	output logic       sclk,
	output logic       mosi,
	input  logic       miso
);

	localparam int CNT_W = $clog2(2 * CLK_DIV + 1);
	localparam logic [CNT_W-1:0] HALF_LAST  = CNT_W'(CLK_DIV - 1);
	localparam logic [CNT_W-1:0] GUARD_LAST = CNT_W'(2 * CLK_DIV - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOW,   // sclk low half, mosi stable
		ST_HIGH,  // sclk high half
		ST_GUARD  // cs_n high time between frames
	} eng_state_t;

	eng_state_t       state;
	logic [CNT_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       tx_shift;
	logic [7:0]       rx_shift;
	logic             end_frame;
	logic             half_done;

	assign tx_ready  = (state == ST_IDLE);
	assign half_done = (div_cnt == HALF_LAST);
	assign rx_data   = rx_shift;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			end_frame <= 1'b0;
			cs_n      <= 1'b1;
			sclk      <= 1'b0;
			mosi      <= 1'b0;
			rx_valid  <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (tx_valid) begin
						mosi      <= tx.data[7]; // msb first
						end_frame <= tx.end_frame;
						cs_n      <= 1'b0;
						div_cnt   <= '0;
						bit_cnt   <= '0;
						state     <= ST_LOW;
					end
				end
				ST_LOW: begin
					if (half_done) begin
						div_cnt <= '0;
						sclk    <= 1'b1; // slave and master both sample here
						state   <= ST_HIGH;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				ST_HIGH: begin
					if (half_done) begin
						div_cnt <= '0;
						sclk    <= 1'b0;
						if (bit_cnt == 3'd7) begin
							rx_valid <= 1'b1;
							if (end_frame) begin
								cs_n  <= 1'b1;
								mosi  <= 1'b0;
								state <= ST_GUARD;
							end else begin
								state <= ST_IDLE; // cs_n stays low
							end
						end else begin
							mosi    <= tx_shift[7];
							bit_cnt <= bit_cnt + 3'd1;
							state   <= ST_LOW;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				ST_GUARD: begin
					if (div_cnt == GUARD_LAST) begin
						div_cnt <= '0;
						state   <= ST_IDLE;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shift registers
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && tx_valid) begin
			tx_shift <= {tx.data[6:0], 1'b0};
		end else if (state == ST_HIGH && half_done && bit_cnt != 3'd7) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
		if (state == ST_LOW && half_done) begin
			rx_shift <= {rx_shift[6:0], miso};
		end
	end

endmodule

/* rtl/flash_program_seq.sv */
`timescale 1ns/1ps

module flash_program_seq import flash_pkg::*; #(
	parameter int POLL_LIMIT = 64
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        start_valid,
	output logic        start_ready,
	output logic        done,
	output logic        error,
	output logic [7:0]  table_index,
	input  logic [23:0] spi_wrdata,
	output spi_byte_t   tx,
	output logic        tx_valid,
	input  logic        tx_ready,
	input  logic [7:0]  rx_data,
	input  logic        rx_valid
);

	localparam int POLL_W = $clog2(POLL_LIMIT + 1);
	localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(POLL_LIMIT - 1);

	seq_state_t        state;
	logic [7:0]        data_idx;
	logic [1:0]        addr_sel;   // which address byte is next
	logic [POLL_W-1:0] poll_cnt;
	logic              dummy_sent; // status byte already handed over
	logic              fail;
	logic              tx_fire;

	assign tx_fire     = tx_valid & tx_ready;
	assign start_ready = (state == IDLE);
	assign done        = (state == FINISH) & ~fail;
	assign error       = (state == FINISH) & fail;

	always_comb begin
		case (state)
			PROG_CMD:  table_index = 8'd1;
			PROG_ADDR: table_index = CFG_ADDR_INDEX;
			PROG_DATA: table_index = data_idx;
			default:   table_index = 8'd0; // write enable entry
		endcase
	end

	// byte handed to the engine
	always_comb begin
		tx.data      = spi_wrdata[7:0];
		tx.end_frame = 1'b0;
		tx_valid     = 1'b0;
		case (state)
			WREN: begin
				tx.end_frame = 1'b1; // single byte frame
				tx_valid     = 1'b1;
			end
			PROG_CMD: begin
				tx_valid = 1'b1;
			end
			PROG_ADDR: begin
				tx_valid = 1'b1;
				case (addr_sel)
					2'd0:    tx.data = spi_wrdata[23:16];
					2'd1:    tx.data = spi_wrdata[15:8];
					default: tx.data = spi_wrdata[7:0];
				endcase
			end
			PROG_DATA: begin
				tx_valid     = 1'b1;
				tx.end_frame = (data_idx == CFG_LAST_INDEX);
			end
			POLL_CMD: begin
				tx.data  = OP_READ_STATUS1;
				tx_valid = 1'b1;
			end
			POLL_READ: begin
				tx.data      = 8'h00; // dummy, clocks status out
				tx.end_frame = 1'b1;
				tx_valid     = ~dummy_sent;
			end
			default: begin
				tx_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			data_idx   <= '0;
			addr_sel   <= '0;
			poll_cnt   <= '0;
			dummy_sent <= 1'b0;
			fail       <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start_valid) begin
						poll_cnt <= '0;
						fail     <= 1'b0;
						state    <= WREN;
					end
				end
				WREN: begin
					if (tx_fire) state <= WREN_GAP;
				end
				WREN_GAP: begin
					if (rx_valid) state <= PROG_CMD; // wren byte out
				end
				PROG_CMD: begin
					if (tx_fire) begin
						addr_sel <= 2'd0;
						state    <= PROG_ADDR;
					end
				end
				PROG_ADDR: begin
					if (tx_fire) begin
						if (addr_sel == 2'd2) begin
							data_idx <= CFG_FIRST_DATA;
							state    <= PROG_DATA;
						end else begin
							addr_sel <= addr_sel + 2'd1;
						end
					end
				end
				PROG_DATA: begin
					if (tx_fire) begin
						if (data_idx == CFG_LAST_INDEX) begin
							state <= POLL_CMD;
						end else begin
							data_idx <= data_idx + 8'd1;
						end
					end
				end
				POLL_CMD: begin
					if (tx_fire) begin
						dummy_sent <= 1'b0;
						state      <= POLL_READ;
					end
				end
				POLL_READ: begin
					if (tx_fire) dummy_sent <= 1'b1;
					// rx of the opcode byte arrives before the dummy is taken
					if (rx_valid && dummy_sent) begin
						poll_cnt <= poll_cnt + 1'b1;
						if (!rx_data[STATUS_BUSY_BIT]) begin
							state <= FINISH;
						end else if (poll_cnt == POLL_LAST) begin
							fail  <= 1'b1;
							state <= FINISH;
						end else begin
							state <= POLL_CMD;
						end
					end
				end
				FINISH: begin
					state <= IDLE; // done/error for this one cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/flash_writer_top.sv */
`timescale 1ns/1ps

module flash_writer_top import flash_pkg::*; #(
	parameter int CLK_DIV    = 2,
	parameter int POLL_LIMIT = 64
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start_valid,
	output logic start_ready,
	output logic done,
	output logic error,
	output logic cs_n,
	output logic sclk,
	output logic mosi,
	input  logic miso
);

	logic [7:0]  table_index;
	logic [23:0] spi_wrdata;
	spi_byte_t   tx;
	logic        tx_valid;
	logic        tx_ready;
	logic [7:0]  rx_data;
	logic        rx_valid;

	flash_program_seq #(
		.POLL_LIMIT (POLL_LIMIT)
	) u_seq (
		.clk         (clk),
		.arst_n      (arst_n),
		.start_valid (start_valid),
		.start_ready (start_ready),
		.done        (done),
		.error       (error),
		.table_index (table_index),
		.spi_wrdata  (spi_wrdata),
		.tx          (tx),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid)
	);

	w25q16_cfg_data u_cfg (
		.index      (table_index),
		.spi_wrdata (spi_wrdata)
	);

	spi_byte_engine #(
		.CLK_DIV (CLK_DIV)
	) u_spi (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx       (tx),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.cs_n     (cs_n),
		.sclk     (sclk),
		.mosi     (mosi),
		.miso     (miso)
	);

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model (
	input  logic cs_n,
	input  logic sclk,
	input  logic mosi,
	output logic miso,
	input  int   busy_reads,  // busy status reads after each page program
	input  logic busy_forever
);

	localparam int MAX_FRAMES = 256;
	localparam int MAX_BYTES  = 2048;

	logic [7:0] byte_log [MAX_BYTES];
	int         frame_start [MAX_FRAMES];
	int         frame_len [MAX_FRAMES];
	int         n_frames = 0;
	int         n_bytes = 0;
	int         cur_len = 0;
	int         bit_n = 0;
	int         busy_left = 0;
	logic [7:0] in_sh = 8'h00;
	logic [7:0] out_sh = 8'h00;
	logic       miso_q = 1'b0;
	logic       cs_q = 1'b1;
	logic       sclk_q = 1'b0;

	assign miso = miso_q;

	// edges found against the previous pin levels
	always @(cs_n or sclk) begin
		if (cs_n === 1'b0 && cs_q !== 1'b0 && n_frames < MAX_FRAMES) begin
			frame_start[n_frames] = n_bytes; // frame opens
			cur_len = 0;
			bit_n   = 0;
			out_sh  = 8'h00;
			miso_q  = 1'b0;
		end
		if (cs_n === 1'b0 && sclk === 1'b1 && sclk_q !== 1'b1) begin
			in_sh = {in_sh[6:0], mosi}; // mode 0 samples on the rise
			bit_n++;
			if (bit_n == 8) begin
				bit_n = 0;
				if (n_bytes < MAX_BYTES) byte_log[n_bytes] = in_sh;
				n_bytes++;
				if (cur_len == 0 && in_sh == 8'h05) begin
					out_sh = (busy_forever || busy_left > 0) ? 8'h03 : 8'h02; // wel kept, only busy drops
					if (busy_left > 0) busy_left--;
				end
				cur_len++;
			end
		end
		if (cs_n === 1'b0 && sclk === 1'b0 && sclk_q === 1'b1) begin
			miso_q = out_sh[7]; // shift out on fall
			out_sh = {out_sh[6:0], 1'b0};
		end
		if (cs_n === 1'b1 && cs_q === 1'b0 && cur_len > 0 && n_frames < MAX_FRAMES) begin
			frame_len[n_frames] = cur_len;
			if (byte_log[frame_start[n_frames]] == 8'h02) busy_left = busy_reads;
			n_frames++;
		end
		cs_q   = cs_n;
		sclk_q = sclk;
	end

endmodule

/* testbench/tb_flash_writer.sv */
`timescale 1ns/1ps

module tb_flash_writer import flash_pkg::*; ();

	localparam int CLK_DIV    = 2;
	localparam int POLL_LIMIT = 64;

	logic clk = 1'b0;
	logic arst_n;
	logic start_valid;
	logic start_ready;
	logic done;
	logic error;
	logic cs_n;
	logic sclk;
	logic mosi;
	logic miso;
	int   busy_reads;
	logic busy_forever;
	int   seed;
	int   cycle_cnt = 0;
	int   cycle_limit = 1000000;
	int   done_cnt = 0;
	int   error_cnt = 0;
	int   accept_cnt = 0;
	logic ready_q = 1'b0;

	flash_writer_top #(.CLK_DIV(CLK_DIV), .POLL_LIMIT(POLL_LIMIT)) dut (.*);

	spi_flash_model flash (.*);

	always #5 clk = ~clk;

	always @(negedge clk) begin
		if (done) done_cnt++;
		if (error) error_cnt++;
		if (ready_q && !start_ready) accept_cnt++; // start_ready only falls on accept
		ready_q = start_ready;
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, sequencer in state %s", cycle_cnt,
				dut.u_seq.state.name());
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	// frame 0 write enable, frame 1 page program, then status polls
	function automatic int ref_len(input int k);
		if (k == 0) return 1;
		if (k == 1) return 152;
		return 2;
	endfunction

	function automatic logic [7:0] ref_byte(input int k, input int pos);
		int n;
		n = pos % 100; // data at pos p comes from entry p-1 and is p mod 100
		if (k == 0) return OP_WRITE_ENABLE;
		if (k >= 2) return (pos == 0) ? OP_READ_STATUS1 : 8'h00;
		case (pos)
			0: return OP_PAGE_PROGRAM;
			1: return 8'h00;
			2: return 8'h04;
			3: return 8'h25;
			default: return 8'((n / 10) * 16 + n % 10); // bcd
		endcase
	endfunction

	// bytes on the wire plus cs_n guard, handshakes and idle gap
	function automatic int job_cycles(input int polls);
		return (153 + 2 * polls) * (16 * CLK_DIV + 1) + (2 + polls) * (2 * CLK_DIV + 4) + 8;
	endfunction

	task automatic abort_run(input string why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
			abort_run("byte mismatch");
		end
	endtask

	task automatic check_op(input string name, input logic [7:0] got, input flash_op_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s got 0x%02h expected 0x%02h %s", $time, name, got, exp,
				exp.name());
			abort_run("opcode mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run("count mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run("flag mismatch");
		end
	endtask

	task automatic check_frames(input int base, input int n);
		int k;
		int p;
		int first;
		for (k = 0; k < n; k++) begin
			first = flash.frame_start[base + k];
			check_count($sformatf("frame %0d length", k), flash.frame_len[base + k], ref_len(k));
			check_op($sformatf("mosi frame %0d opcode", k), flash.byte_log[first],
				flash_op_t'(ref_byte(k, 0)));
			for (p = 1; p < ref_len(k); p++) begin
				check_byte($sformatf("mosi frame %0d byte %0d", k, p),
					flash.byte_log[first + p], ref_byte(k, p));
			end
		end
	endtask

	task automatic start_job(input int gap, input logic hold);
		repeat (gap) @(negedge clk);
		check_flag("start_ready", start_ready, 1'b1);
		start_valid = 1'b1;
		@(negedge clk);
		check_flag("start_ready", start_ready, 1'b0);
		if (!hold) start_valid = 1'b0;
	endtask

	task automatic finish_job(input int base, input int polls, input logic exp_err,
			input int exp_acc, input logic drop_start);
		int done0;
		int err0;
		done0 = done_cnt;
		err0  = error_cnt;
		do @(negedge clk); while (!done && !error);
		if (drop_start) start_valid = 1'b0;
		check_flag("done", done, !exp_err);
		check_flag("error", error, exp_err);
		check_flag("cs_n", cs_n, 1'b1);
		check_count("frames before next job", flash.n_frames - base, 2 + polls);
		check_count("accepted jobs", accept_cnt, exp_acc);
		@(negedge clk);
		check_flag("start_ready", start_ready, 1'b1);
		check_count("done pulses", done_cnt - done0, exp_err ? 0 : 1);
		check_count("error pulses", error_cnt - err0, exp_err ? 1 : 0);
		check_frames(base, 2 + polls);
	endtask

	initial begin
		int b_one;
		int b_chain;
		int base;
		int j;
		seed = 32'h360a_fd39;
		arst_n = 1'b0;
		start_valid = 1'b0;
		busy_reads = 0;
		busy_forever = 1'b0;
		b_one = {$random(seed)} % 6;
		b_chain = {$random(seed)} % 6;
		cycle_limit = 4 * (job_cycles(b_one + 1) + job_cycles(POLL_LIMIT)
			+ 3 * job_cycles(b_chain + 1));
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		check_flag("cs_n", cs_n, 1'b1);
		check_flag("sclk", sclk, 1'b0);
		check_flag("mosi", mosi, 1'b0);
		check_flag("start_ready", start_ready, 1'b1);
		check_flag("done", done, 1'b0);
		check_flag("error", error, 1'b0);
		// one job with the flash busy for b_one reads
		base = flash.n_frames;
		busy_reads = b_one;
		start_job({$random(seed)} % 8, 1'b0);
		finish_job(base, b_one + 1, 1'b0, 1, 1'b0);
		// flash never clears busy
		base = flash.n_frames;
		busy_forever = 1'b1;
		start_job({$random(seed)} % 8, 1'b0);
		finish_job(base, POLL_LIMIT, 1'b1, 2, 1'b0);
		busy_forever = 1'b0;
		// three jobs back to back with start_valid held high
		busy_reads = b_chain;
		start_job({$random(seed)} % 8, 1'b1);
		for (j = 0; j < 3; j++) begin
			base = flash.n_frames;
			finish_job(base, b_chain + 1, 1'b0, 3 + j, j == 2);
		end
		repeat (2) @(negedge clk);
		check_flag("start_ready", start_ready, 1'b1);
		check_count("accepted jobs at end", accept_cnt, 5);
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* vlog.f */
rtl/flash_pkg.sv
rtl/w25q16_cfg_data.sv
rtl/spi_byte_engine.sv
rtl/flash_program_seq.sv
rtl/flash_writer_top.sv
testbench/spi_flash_model.sv
testbench/tb_flash_writer.sv

/* Makefile */
# Verilator build and run of the flash writer testbench

SIM      ?= verilator
TOP      ?= tb_flash_writer
FILELIST ?= vlog.f
FLAGS    ?= --binary --timing -j 0 -Wno-fatal
BUILD    ?= obj_dir

.PHONY: sim clean

# the binary exits non-zero on $fatal, so make fails with the testbench
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
